/* fu_macros.svh */
`ifndef FU_MACROS_SVH
`define FU_MACROS_SVH

// Datapath and lane sizing
`define XLEN        64
`define NUM_ALU     2
`define MULT_STAGES 4   // Must divide XLEN evenly
`define CQ_DEPTH    16  // Power of two, queue pointers wrap
`define TAG_W       6

// Instruction fields
`define IMM_W       16  // Sign-extended literal
`define DISP_W      21  // Branch displacement in words

`define TRUE  1'b1
`define FALSE 1'b0

`endif

/* fu_pkg.sv */
`include "fu_macros.svh"

package fu_pkg;

  // ALU_MULQ is steered to the multiplier, never to an ALU lane
  typedef enum logic [4:0] {
    ALU_ADDQ   = 5'h00,
    ALU_SUBQ   = 5'h01,
    ALU_AND    = 5'h02,
    ALU_BIC    = 5'h03,
    ALU_BIS    = 5'h04,
    ALU_ORNOT  = 5'h05,
    ALU_XOR    = 5'h06,
    ALU_EQV    = 5'h07,
    ALU_SRL    = 5'h08,
    ALU_SLL    = 5'h09,
    ALU_SRA    = 5'h0a,
    ALU_MULQ   = 5'h0b,
    ALU_CMPULT = 5'h0c,
    ALU_CMPEQ  = 5'h0d,
    ALU_CMPULE = 5'h0e,
    ALU_CMPLT  = 5'h0f,
    ALU_CMPLE  = 5'h10
  } alu_func_t;

  typedef struct packed {
    logic              ready;
    alu_func_t         func;
    logic [`TAG_W-1:0] tag;
    logic [`XLEN-1:0]  T1_value;
    logic [`XLEN-1:0]  T2_value;
    logic [`IMM_W-1:0] imm;
    logic              use_imm;   // Take imm in place of T2_value
  } fu_packet_t;

  typedef struct packed {
    logic               ready;
    logic [2:0]         func;     // [2] negate, [1:0] condition
    logic [`TAG_W-1:0]  tag;
    logic [`XLEN-1:0]   T1_value;
    logic [`XLEN-1:0]   pc;
    logic [`DISP_W-1:0] disp;
  } br_packet_t;

  typedef struct packed {
    fu_packet_t [`NUM_ALU-1:0] alu;
    fu_packet_t                mult;
    br_packet_t                br;
  } issue_bundle_t;

  typedef struct packed {
    logic              valid;
    logic [`TAG_W-1:0] tag;
    logic [`XLEN-1:0]  value;
  } fu_result_t;

  typedef struct packed {
    logic              valid;
    logic [`TAG_W-1:0] tag;
    logic              taken;
    logic [`XLEN-1:0]  target;
  } br_result_t;

endpackage

/* fu_issue_stage.sv */
`timescale 1ns/100ps
`include "fu_macros.svh"

module fu_issue_stage (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              flush,
  input  fu_pkg::issue_bundle_t             issue,
  output fu_pkg::fu_packet_t [`NUM_ALU-1:0] alu_pkt,
  output fu_pkg::fu_packet_t                mult_pkt,
  output fu_pkg::br_packet_t                br_pkt
);

  fu_pkg::issue_bundle_t bundle_n;
  fu_pkg::issue_bundle_t bundle_q;

  function automatic logic [`XLEN-1:0] sext_imm(input logic [`IMM_W-1:0] imm);
    return {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm};
  endfunction

  // Operand select ahead of the register
  always_comb begin
    bundle_n = issue;
    for (int i = 0; i < `NUM_ALU; i++) begin
      if (issue.alu[i].use_imm) begin
        bundle_n.alu[i].T2_value = sext_imm(issue.alu[i].imm);
      end
    end
    if (issue.mult.use_imm) begin
      bundle_n.mult.T2_value = sext_imm(issue.mult.imm);
    end
  end

  always_ff @(posedge clock) begin
    bundle_q <= bundle_n;
    // Incoming bundle is dropped on a flush
    if (reset || flush) begin
      for (int i = 0; i < `NUM_ALU; i++) begin
        bundle_q.alu[i].ready <= `FALSE;
      end
      bundle_q.mult.ready <= `FALSE;
      bundle_q.br.ready   <= `FALSE;
    end
  end

  assign alu_pkt  = bundle_q.alu;
  assign mult_pkt = bundle_q.mult;
  assign br_pkt   = bundle_q.br;

endmodule

/* alu.sv */
`timescale 1ns/100ps
`include "fu_macros.svh"

module alu (
  input  fu_pkg::fu_packet_t fu_packet,
  output fu_pkg::fu_result_t result
);

  localparam int SHAMT_W = $clog2(`XLEN);

  logic [`XLEN-1:0]   t1;
  logic [`XLEN-1:0]   t2;
  logic [SHAMT_W-1:0] shamt;

  // Signed less-than without a signed cast
  function automatic logic signed_lt(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
    if (a[`XLEN-1] == b[`XLEN-1]) begin
      return (a < b);   // Same sign, unsigned order holds
    end
    return a[`XLEN-1];  // Negative side is smaller
  endfunction

  assign t1    = fu_packet.T1_value;
  assign t2    = fu_packet.T2_value;
  assign shamt = t2[SHAMT_W-1:0];

  assign result.valid = (fu_packet.ready == `TRUE);
  assign result.tag   = fu_packet.tag;

  always_comb begin
    case (fu_packet.func)
      fu_pkg::ALU_ADDQ:   result.value = t1 + t2;
      fu_pkg::ALU_SUBQ:   result.value = t1 - t2;
      fu_pkg::ALU_AND:    result.value = t1 & t2;
      fu_pkg::ALU_BIC:    result.value = t1 & ~t2;
      fu_pkg::ALU_BIS:    result.value = t1 | t2;
      fu_pkg::ALU_ORNOT:  result.value = t1 | ~t2;
      fu_pkg::ALU_XOR:    result.value = t1 ^ t2;
      fu_pkg::ALU_EQV:    result.value = t1 ^ ~t2;
      fu_pkg::ALU_SRL:    result.value = t1 >> shamt;
      fu_pkg::ALU_SLL:    result.value = t1 << shamt;
      // Fill the vacated top bits with the sign; shift of 64 clears the fill
      fu_pkg::ALU_SRA: begin
        result.value = (t1 >> shamt) | ({`XLEN{t1[`XLEN-1]}} << (`XLEN - shamt));
      end
      fu_pkg::ALU_CMPULT: result.value = {{(`XLEN-1){1'b0}}, (t1 < t2)};
      fu_pkg::ALU_CMPEQ:  result.value = {{(`XLEN-1){1'b0}}, (t1 == t2)};
      fu_pkg::ALU_CMPULE: result.value = {{(`XLEN-1){1'b0}}, (t1 <= t2)};
      fu_pkg::ALU_CMPLT:  result.value = {{(`XLEN-1){1'b0}}, signed_lt(t1, t2)};
      fu_pkg::ALU_CMPLE: begin
        result.value = {{(`XLEN-1){1'b0}}, (signed_lt(t1, t2) || (t1 == t2))};
      end
      default:            result.value = 64'hdeadbeefbaadbeef;  // Marks a bad func
    endcase
  end

endmodule

/* mult.sv */
`timescale 1ns/100ps
`include "fu_macros.svh"

module mult (
  input  logic               clock,
  input  logic               reset,
  input  logic               flush,
  input  fu_pkg::fu_packet_t fu_packet,
  output fu_pkg::fu_result_t result
);

  localparam int STEP = `XLEN / `MULT_STAGES;  // Multiplier bits per stage

  typedef struct packed {
    logic              valid;
    logic [`TAG_W-1:0] tag;
    logic [`XLEN-1:0]  mcand;   // Moves left one step per stage
    logic [`XLEN-1:0]  mplier;  // Low STEP bits consumed per stage
    logic [`XLEN-1:0]  prod;
  } stage_t;

  stage_t [`MULT_STAGES-1:0] stage_in;
  stage_t [`MULT_STAGES-1:0] stage_q;

  // One partial product step, low XLEN bits kept
  function automatic stage_t fold(input stage_t s);
    stage_t f;
    f        = s;
    f.prod   = s.prod + s.mcand * s.mplier[STEP-1:0];
    f.mcand  = s.mcand << STEP;
    f.mplier = s.mplier >> STEP;
    return f;
  endfunction

  always_comb begin
    stage_in[0].valid  = fu_packet.ready;
    stage_in[0].tag    = fu_packet.tag;
    stage_in[0].mcand  = fu_packet.T1_value;
    stage_in[0].mplier = fu_packet.T2_value;
    stage_in[0].prod   = '0;
    for (int i = 1; i < `MULT_STAGES; i++) begin
      stage_in[i] = stage_q[i-1];
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < `MULT_STAGES; i++) begin
      stage_q[i] <= fold(stage_in[i]);
      if (reset || flush) stage_q[i].valid <= `FALSE;  // Whole pipe killed
    end
  end

  assign result.valid = stage_q[`MULT_STAGES-1].valid;
  assign result.tag   = stage_q[`MULT_STAGES-1].tag;
  assign result.value = stage_q[`MULT_STAGES-1].prod;

endmodule

/* brcond.sv */
`timescale 1ns/100ps
`include "fu_macros.svh"

module brcond (
  input  logic               clock,
  input  logic               reset,
  input  fu_pkg::br_packet_t br_packet,
  output fu_pkg::br_result_t br_out
);

  logic             cond;
  logic [`XLEN-1:0] disp_ext;
  logic [`XLEN-1:0] target;

  always_comb begin
    case (br_packet.func[1:0])
      2'b00:   cond = (br_packet.T1_value[0] == 1'b0);  // LBC
      2'b01:   cond = (br_packet.T1_value == '0);       // EQ
      2'b10:   cond = br_packet.T1_value[`XLEN-1];      // LT, sign bit only
      default: cond = br_packet.T1_value[`XLEN-1] || (br_packet.T1_value == '0);  // LE
    endcase
  end

  // Word displacement to byte offset
  assign disp_ext = {{(`XLEN-`DISP_W-2){br_packet.disp[`DISP_W-1]}}, br_packet.disp, 2'b00};
  assign target   = br_packet.pc + `XLEN'(4) + disp_ext;

  always_ff @(posedge clock) begin
    if (reset) begin
      br_out.valid <= `FALSE;
    end else begin
      br_out.valid <= br_packet.ready;
    end
    br_out.tag    <= br_packet.tag;
    br_out.taken  <= cond ^ br_packet.func[2];  // func[2] negates
    br_out.target <= target;
  end

endmodule

/* completion_queue.sv */
`timescale 1ns/100ps
`include "fu_macros.svh"

module completion_queue (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            flush,
  input  fu_pkg::fu_result_t [`NUM_ALU:0] results,
  output fu_pkg::fu_result_t              cdb,
  output logic                            stall
);

  localparam int NW         = `NUM_ALU + 1;
  localparam int PTR_W      = $clog2(`CQ_DEPTH);
  localparam int CNT_W      = $clog2(`CQ_DEPTH + 1);
  localparam int NWR_W      = $clog2(NW + 1);
  localparam int STALL_FREE = NW * (`MULT_STAGES + 1);  // Worst case still in flight

  fu_pkg::fu_result_t mem [`CQ_DEPTH];

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] free;
  logic [NWR_W-1:0] n_wr;
  logic [NW-1:0]    wr_en;
  logic [PTR_W-1:0] wr_idx [NW];
  logic             pop;

  assign free = CNT_W'(`CQ_DEPTH) - count;
  assign pop  = (count != '0);

  // Compact valid inputs in index order, mult sits at index 0
  always_comb begin
    n_wr = '0;
    for (int i = 0; i < NW; i++) begin
      wr_idx[i] = tail + PTR_W'(n_wr);
      wr_en[i]  = results[i].valid && (CNT_W'(n_wr) < free);  // Lost if full
      n_wr      = n_wr + NWR_W'(wr_en[i]);
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < NW; i++) begin
      if (wr_en[i]) mem[wr_idx[i]] <= results[i];
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + PTR_W'(pop);
      tail  <= tail + PTR_W'(n_wr);
      count <= count + CNT_W'(n_wr) - CNT_W'(pop);
    end
  end

  // Head entry is broadcast while the queue is non-empty
  assign cdb.valid = pop;
  assign cdb.tag   = mem[head].tag;
  assign cdb.value = mem[head].value;

  assign stall = (free < CNT_W'(STALL_FREE));

endmodule

/* fu_top.sv */
`timescale 1ns/100ps
`include "fu_macros.svh"

module fu_top (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  flush,
  input  fu_pkg::issue_bundle_t issue,
  output fu_pkg::fu_result_t    cdb,
  output fu_pkg::br_result_t    br_out,
  output logic                  stall
);

  fu_pkg::fu_packet_t [`NUM_ALU-1:0] alu_pkt;
  fu_pkg::fu_packet_t                mult_pkt;
  fu_pkg::br_packet_t                br_pkt;
  fu_pkg::fu_result_t [`NUM_ALU:0]   wb_results;  // [0] mult, then ALU lanes

  fu_issue_stage issue_0 (
    .clock   (clock),
    .reset   (reset),
    .flush   (flush),
    .issue   (issue),
    .alu_pkt (alu_pkt),
    .mult_pkt(mult_pkt),
    .br_pkt  (br_pkt)
  );

  for (genvar i = 0; i < `NUM_ALU; i++) begin : g_alu
    alu alu_0 (
      .fu_packet(alu_pkt[i]),
      .result   (wb_results[i+1])
    );
  end

  mult mult_0 (
    .clock    (clock),
    .reset    (reset),
    .flush    (flush),
    .fu_packet(mult_pkt),
    .result   (wb_results[0])
  );

  brcond br_0 (
    .clock    (clock),
    .reset    (reset),
    .br_packet(br_pkt),
    .br_out   (br_out)
  );

  completion_queue cq_0 (
    .clock  (clock),
    .reset  (reset),
    .flush  (flush),
    .results(wb_results),
    .cdb    (cdb),
    .stall  (stall)
  );

endmodule

/* fu_props.sv */
`timescale 1ns/100ps
`include "fu_macros.svh"

module fu_props (
  input logic                  clock,
  input logic                  reset,
  input logic                  flush,
  input fu_pkg::issue_bundle_t issue,
  input fu_pkg::fu_result_t    cdb,
  input fu_pkg::br_result_t    br_out,
  input logic                  stall
);

  logic any_ready;

  always_comb begin
    any_ready = issue.mult.ready || issue.br.ready;
    for (int i = 0; i < `NUM_ALU; i++) begin
      any_ready = any_ready || issue.alu[i].ready;
    end
  end

  // Upstream holds every lane idle while the queue is near full
  stall_honoured: assert property (@(posedge clock) disable iff (reset) stall |-> !any_ready)
    else $error("packet issued while stall was high");

  reset_clears: assert property (@(posedge clock) reset |=> !cdb.valid && !stall)
    else $error("cdb valid or stall set after reset");

  // A branch sampled without flush resolves two edges later
  br_latency: assert property (@(posedge clock) disable iff (reset)
    issue.br.ready && !flush |-> ##2 br_out.valid)
    else $error("branch outcome missing two edges after issue");

endmodule

/* tb_fu_top.sv */
`timescale 1ns/100ps
`include "fu_macros.svh"

module tb_fu_top;

  logic                  clock;
  logic                  reset;
  logic                  flush;
  fu_pkg::issue_bundle_t issue;
  fu_pkg::fu_result_t    cdb;
  fu_pkg::br_result_t    br_out;
  logic                  stall;

  logic [31:0]        seed = 32'hf39d;
  logic [`XLEN-1:0]   exp_val [1<<`TAG_W];  // Expected value by tag
  logic               pending [1<<`TAG_W];
  fu_pkg::br_result_t br_exp [4];           // Slot is due cycle mod 4
  logic [`TAG_W-1:0]  next_tag = '0;
  logic               saw_stall = 1'b0;
  logic               drained = 1'b1;
  int                 n_pending = 0;
  int                 errors = 0;
  int                 checks = 0;
  int                 cycle = 0;
  int                 alu_count = 0;
  int                 br_count = 0;

  fu_top DUT (
    .clock (clock),
    .reset (reset),
    .flush (flush),
    .issue (issue),
    .cdb   (cdb),
    .br_out(br_out),
    .stall (stall)
  );

  bind fu_top fu_props props_0 (
    .clock (clock),
    .reset (reset),
    .flush (flush),
    .issue (issue),
    .cdb   (cdb),
    .br_out(br_out),
    .stall (stall)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) cycle <= cycle + 1;

  function automatic logic [31:0] lcg();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Corner values mixed with random ones
  function automatic logic [`XLEN-1:0] pick_operand();
    logic [31:0] r;
    r = lcg();
    case (r[31:29])
      3'd0:    return '0;
      3'd1:    return '1;
      3'd2:    return {1'b1, {(`XLEN-1){1'b0}}};
      3'd3:    return `XLEN'(63);
      default: return {lcg(), lcg()};
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] ref_alu(input fu_pkg::alu_func_t f,
                                               input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] b);
    case (f)
      fu_pkg::ALU_ADDQ:   return a + b;
      fu_pkg::ALU_SUBQ:   return a - b;
      fu_pkg::ALU_AND:    return a & b;
      fu_pkg::ALU_BIC:    return a & ~b;
      fu_pkg::ALU_BIS:    return a | b;
      fu_pkg::ALU_ORNOT:  return a | ~b;
      fu_pkg::ALU_XOR:    return a ^ b;
      fu_pkg::ALU_EQV:    return ~(a ^ b);
      fu_pkg::ALU_SRL:    return a >> b[5:0];
      fu_pkg::ALU_SLL:    return a << b[5:0];
      fu_pkg::ALU_SRA:    return $signed(a) >>> b[5:0];
      fu_pkg::ALU_MULQ:   return a * b;  // Low half of the product
      fu_pkg::ALU_CMPULT: return `XLEN'(a < b);
      fu_pkg::ALU_CMPEQ:  return `XLEN'(a == b);
      fu_pkg::ALU_CMPULE: return `XLEN'(a <= b);
      fu_pkg::ALU_CMPLT:  return `XLEN'($signed(a) < $signed(b));
      fu_pkg::ALU_CMPLE:  return `XLEN'($signed(a) <= $signed(b));
      default:            return '0;
    endcase
  endfunction

  function automatic fu_pkg::br_result_t ref_br(input fu_pkg::br_packet_t p);
    fu_pkg::br_result_t r;
    logic               cond;
    case (p.func[1:0])
      2'd0:    cond = !p.T1_value[0];
      2'd1:    cond = (p.T1_value == '0);
      2'd2:    cond = ($signed(p.T1_value) < 0);
      default: cond = ($signed(p.T1_value) <= 0);
    endcase
    r.valid  = 1'b1;
    r.tag    = p.tag;
    r.taken  = cond ^ p.func[2];
    r.target = p.pc + 4 + 4 * `XLEN'($signed(p.disp));
    return r;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_val(input string name, input logic [`XLEN-1:0] got,
                           input logic [`XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic record_result(input fu_pkg::fu_packet_t p);
    logic [`XLEN-1:0] b;
    b = p.use_imm ? `XLEN'($signed(p.imm)) : p.T2_value;
    if (pending[p.tag]) begin
      report_error($sformatf("tag %0d reissued while still outstanding", p.tag));
    end else begin
      n_pending++;
    end
    pending[p.tag] = 1'b1;
    exp_val[p.tag] = ref_alu(p.func, p.T1_value, b);
  endtask

  // The DUT discards packets issued with a flush so none is expected
  task automatic issue_cycle(input logic do_flush, input logic mult_only);
    fu_pkg::issue_bundle_t           b;
    fu_pkg::fu_packet_t [`NUM_ALU:0] pk;
    int                              k;
    logic [31:0]                     r;
    b  = '0;
    pk = '0;
    if (stall) begin
      saw_stall = 1'b1;
    end else begin
      for (int i = 0; i <= `NUM_ALU; i++) begin
        if (mult_only && i < `NUM_ALU) continue;  // ALU lanes stay idle
        k = alu_count % 16;
        r = lcg();
        pk[i].ready    = 1'b1;
        pk[i].func     = fu_pkg::alu_func_t'(5'((k < 11) ? k : k + 1));  // Skip MULQ
        if (i == `NUM_ALU) pk[i].func = fu_pkg::ALU_MULQ;
        pk[i].tag      = next_tag;
        pk[i].T1_value = pick_operand();
        pk[i].T2_value = pick_operand();
        pk[i].imm      = r[15:0];
        pk[i].use_imm  = r[16];
        if (!do_flush) record_result(pk[i]);
        next_tag++;
        if (i < `NUM_ALU) alu_count++;
      end
      b.alu         = pk[`NUM_ALU-1:0];
      b.mult        = pk[`NUM_ALU];
      r             = lcg();
      b.br.ready    = 1'b1;
      b.br.func     = 3'(br_count);  // Walks all eight codes
      b.br.tag      = `TAG_W'(br_count);
      b.br.T1_value = pick_operand();
      b.br.pc       = {lcg(), r[31:2], 2'b00};
      b.br.disp     = `DISP_W'(lcg());
      if (!do_flush) br_exp[(cycle + 2) % 4] = ref_br(b.br);
      br_count++;
    end
    issue = b;
    flush = do_flush;
  endtask

  task automatic run_cycles(input int n, input logic active, input logic do_flush,
                            input logic mult_only);
    repeat (n) begin
      @(posedge clock);
      if (flush) begin  // Flush took effect at this edge
        for (int t = 0; t < (1 << `TAG_W); t++) pending[t] = 1'b0;
        n_pending = 0;
      end
      #1;
      if (active) begin
        issue_cycle(do_flush, mult_only);
      end else begin
        issue = '0;
        flush = do_flush;
      end
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic wait_drain(input string what, output logic done);
    int waited;
    waited = 0;
    while ((n_pending != 0 || stall) && waited < 200) begin
      run_cycles(1, 1'b0, 1'b0, 1'b0);
      waited++;
    end
    done = (n_pending == 0 && !stall);
    if (!done) begin
      report_error($sformatf("timed out waiting for %s, %0d left", what, n_pending));
    end
  endtask

  // Scoreboard samples mid-cycle while outputs are settled
  always @(negedge clock) begin
    if (!reset) begin
      if (cdb.valid) begin
        if (!pending[cdb.tag]) begin
          report_error($sformatf("cdb carried tag %0d with no outstanding result", cdb.tag));
        end else begin
          check_val("cdb.value", cdb.value, exp_val[cdb.tag]);
          pending[cdb.tag] = 1'b0;
          n_pending--;
        end
      end
      check_val("br_out.valid", br_out.valid, br_exp[cycle % 4].valid);
      if (br_exp[cycle % 4].valid) begin
        check_val("br_out.tag", br_out.tag, br_exp[cycle % 4].tag);
        check_val("br_out.taken", br_out.taken, br_exp[cycle % 4].taken);
        check_val("br_out.target", br_out.target, br_exp[cycle % 4].target);
      end
      br_exp[cycle % 4] = '0;
    end
  end

  initial begin
    for (int t = 0; t < (1 << `TAG_W); t++) pending[t] = 1'b0;
    for (int s = 0; s < 4; s++) br_exp[s] = '0;
    reset = 1'b1;
    flush = 1'b0;
    issue = '0;
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    run_cycles(300, 1'b1, 1'b0, 1'b0);  // Every lane whenever stall is low
    wait_drain("queue to empty after full-rate issue", drained);
    if (!saw_stall) report_error("stall never rose under full-rate issue");
    if (drained) begin
      run_cycles(20, 1'b1, 1'b0, 1'b1);  // One multiply per cycle
      wait_drain("back-to-back multiplies", drained);
    end
    if (drained) begin
      run_cycles(6, 1'b1, 1'b0, 1'b0);
      run_cycles(1, 1'b1, 1'b1, 1'b0);
      run_cycles(`MULT_STAGES + 2, 1'b0, 1'b0, 1'b0);  // Stale tags would surface here
      run_cycles(40, 1'b1, 1'b0, 1'b0);
      wait_drain("results issued after the flush", drained);
    end
    if (drained) run_cycles(4, 1'b0, 1'b0, 1'b0);  // Last branch outcomes
    finish_run();
  end

endmodule

/* filelist.f */
+incdir+.
fu_pkg.sv
fu_issue_stage.sv
alu.sv
mult.sv
brcond.sv
completion_queue.sv
fu_top.sv
fu_props.sv
tb_fu_top.sv
